//--- flist.f
hdl/gcode_pkg.sv
hdl/line_buffer.sv
hdl/char_reader.sv
hdl/cmd_subparser_fsm.sv
hdl/code_num_buffer.sv
hdl/cmd_subparser.sv
test/cmd_subparser_chk.sv
test/cmd_subparser_tb.sv

//--- hdl/char_reader.sv
`timescale 1ns/1ps

module char_reader (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    clk_en,
	input  logic                    rd_trigger,
	input  gcode_pkg::char_t        rd_data,
	output logic                    rd_pop,
	output logic                    rd_rdy,
	output logic                    rd_done,
	output gcode_pkg::char_t        char,
	output gcode_pkg::char_type_t   char_type
);

	typedef enum logic [1:0] {
		IDLE,
		FETCH,
		CLASSIFY
	} state_t;

	state_t                state;
	state_t                next_state;
	gcode_pkg::char_type_t next_type;

	assign rd_pop  = (state == FETCH);
	assign rd_rdy  = (state != FETCH); // back up as the character lands.
	assign rd_done = (state == CLASSIFY);

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (rd_trigger) begin
					next_state = FETCH;
				end
			end
			FETCH: next_state = CLASSIFY;
			CLASSIFY: next_state = IDLE;
			default: next_state = IDLE;
		endcase
	end

	// type of the character coming out of the buffer.
	always_comb begin
		if (rd_data == "G" || rd_data == "g") begin
			next_type = gcode_pkg::CHAR_G;
		end
		else if (rd_data >= "0" && rd_data <= "9") begin
			next_type = gcode_pkg::CHAR_NUM;
		end
		else if (rd_data == " ") begin
			next_type = gcode_pkg::CHAR_SPACE;
		end
		else if (rd_data == 8'h0a || rd_data == 8'h0d) begin
			next_type = gcode_pkg::CHAR_NEWLINE; // lf or cr.
		end
		else begin
			next_type = gcode_pkg::CHAR_OTHER;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= IDLE;
			char      <= '0;
			char_type <= gcode_pkg::CHAR_OTHER;
		end
		else if (clk_en) begin
			state <= next_state;
			if (state == CLASSIFY) begin
				char      <= rd_data; // held until the next read.
				char_type <= next_type;
			end
		end
	end

endmodule : char_reader

//--- hdl/cmd_subparser.sv
`timescale 1ns/1ps

module cmd_subparser #(
	parameter int BUF_DEPTH = 16
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                clk_en,
	input  logic                wr_en,
	input  gcode_pkg::char_t    wr_char,
	input  logic                trigger,
	output logic                full,
	output logic                rdy,
	output logic                done,
	output logic                success,
	output gcode_pkg::num_t     cmd_num,
	output gcode_pkg::char_t    last_char
);

	logic                  rd_pop;
	logic                  is_empty;
	logic                  rd_trigger;
	logic                  rd_rdy;
	logic                  rd_done;
	logic                  zero;
	logic                  store;
	logic                  advance_num;
	logic                  set_success;
	logic                  is_valid;
	gcode_pkg::char_t      rd_data;
	gcode_pkg::char_t      char;
	gcode_pkg::char_type_t char_type;

	line_buffer #(
		.BUF_DEPTH (BUF_DEPTH)
	) u_line_buffer (
		.clk      (clk),
		.reset    (reset),
		.clk_en   (clk_en),
		.wr_en    (wr_en),
		.wr_char  (wr_char),
		.rd_pop   (rd_pop),
		.rd_data  (rd_data),
		.is_empty (is_empty),
		.full     (full)
	);

	char_reader u_char_reader (
		.clk        (clk),
		.reset      (reset),
		.clk_en     (clk_en),
		.rd_trigger (rd_trigger),
		.rd_data    (rd_data),
		.rd_pop     (rd_pop),
		.rd_rdy     (rd_rdy),
		.rd_done    (rd_done),
		.char       (char),
		.char_type  (char_type)
	);

	cmd_subparser_fsm u_cmd_subparser_fsm (
		.clk         (clk),
		.reset       (reset),
		.clk_en      (clk_en),
		.trigger     (trigger),
		.rd_done     (rd_done),
		.rd_rdy      (rd_rdy),
		.is_empty    (is_empty),
		.is_valid    (is_valid),
		.char_type   (char_type),
		.done        (done),
		.rdy         (rdy),
		.rd_trigger  (rd_trigger),
		.set_success (set_success),
		.advance_num (advance_num),
		.zero        (zero),
		.store       (store)
	);

	code_num_buffer u_code_num_buffer (
		.clk         (clk),
		.reset       (reset),
		.clk_en      (clk_en),
		.zero        (zero),
		.store       (store),
		.advance_num (advance_num),
		.set_success (set_success),
		.char        (char),
		.is_valid    (is_valid),
		.cmd_num     (cmd_num),
		.last_char   (last_char),
		.success     (success)
	);

endmodule : cmd_subparser

//--- hdl/cmd_subparser_fsm.sv
`timescale 1ns/1ps

module cmd_subparser_fsm (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    clk_en,
	input  logic                    trigger,
	input  logic                    rd_done,
	input  logic                    rd_rdy,
	input  logic                    is_empty,
	input  logic                    is_valid,
	input  gcode_pkg::char_type_t   char_type,
	output logic                    done,
	output logic                    rdy,
	output logic                    rd_trigger,
	output logic                    set_success,
	output logic                    advance_num,
	output logic                    zero,
	output logic                    store
);

	typedef enum logic [3:0] {
		IDLE,
		CODE_TRIGGER,
		CODE_WAIT,
		CODE_CHECK,
		WAIT_RD_RDY_1,
		NUM_TRIGGER_1,
		NUM_WAIT_1,
		NUM_ADVANCE_1,
		WAIT_RD_RDY_2,
		NUM_TRIGGER_2,
		NUM_WAIT_2,
		NUM_ADVANCE_2,
		NUM_CHECK,
		SET_SUCCESS,
		DONE
	} state_t;

	state_t state;
	state_t next_state;

	always_comb begin
		next_state  = state;
		done        = 1'b0;
		rdy         = 1'b0;
		rd_trigger  = 1'b0;
		set_success = 1'b0;
		advance_num = 1'b0;
		zero        = 1'b0;
		store       = 1'b0;
		case (state)
			IDLE: begin
				done  = 1'b1;
				rdy   = 1'b1;
				store = 1'b1; // keeps last_char on the final character read.
				if (trigger && rd_rdy && !is_empty) begin
					next_state = CODE_TRIGGER;
				end
			end
			CODE_TRIGGER: begin
				rd_trigger = 1'b1; // held until the reader takes it.
				zero       = 1'b1; // fresh result for this command.
				if (!rd_rdy) begin
					next_state = CODE_WAIT;
				end
			end
			CODE_WAIT: begin
				if (rd_done) begin
					next_state = CODE_CHECK;
				end
			end
			CODE_CHECK: begin
				next_state = WAIT_RD_RDY_1;
				if (char_type != gcode_pkg::CHAR_G) begin
					next_state = DONE; // not a G word.
					done       = 1'b1;
				end
			end
			WAIT_RD_RDY_1: begin
				store = 1'b1;
				if (rd_rdy && !is_empty) begin
					next_state = NUM_TRIGGER_1; // stalls here on an empty line.
				end
			end
			NUM_TRIGGER_1: begin
				rd_trigger = 1'b1;
				if (!rd_rdy) begin
					next_state = NUM_WAIT_1;
				end
			end
			NUM_WAIT_1: begin
				if (rd_done) begin
					next_state = NUM_ADVANCE_1;
				end
			end
			NUM_ADVANCE_1: begin
				next_state  = WAIT_RD_RDY_2;
				advance_num = 1'b1;
				if (char_type != gcode_pkg::CHAR_NUM) begin
					next_state = DONE;
					done       = 1'b1;
				end
			end
			WAIT_RD_RDY_2: begin
				store = 1'b1;
				if (rd_rdy && !is_empty) begin
					next_state = NUM_TRIGGER_2;
				end
			end
			NUM_TRIGGER_2: begin
				rd_trigger = 1'b1;
				if (!rd_rdy) begin
					next_state = NUM_WAIT_2;
				end
			end
			NUM_WAIT_2: begin
				if (rd_done) begin
					next_state = NUM_ADVANCE_2;
				end
			end
			NUM_ADVANCE_2: begin
				next_state  = NUM_CHECK;
				advance_num = 1'b1;
				if (char_type != gcode_pkg::CHAR_NUM) begin
					next_state = DONE;
					done       = 1'b1;
				end
			end
			NUM_CHECK: begin
				next_state = DONE;
				done       = 1'b1;
				if (is_valid) begin
					next_state = SET_SUCCESS; // number is in the supported table.
					done       = 1'b0;
				end
			end
			SET_SUCCESS: begin
				next_state  = DONE;
				set_success = 1'b1;
			end
			DONE: begin
				next_state = IDLE;
				done       = 1'b1;
			end
			default: next_state = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
		end
		else if (clk_en) begin
			state <= next_state;
		end
	end

endmodule : cmd_subparser_fsm

//--- hdl/code_num_buffer.sv
`timescale 1ns/1ps

module code_num_buffer (
	input  logic                clk,
	input  logic                reset,
	input  logic                clk_en,
	input  logic                zero,
	input  logic                store,
	input  logic                advance_num,
	input  logic                set_success,
	input  gcode_pkg::char_t    char,
	output logic                is_valid,
	output gcode_pkg::num_t     cmd_num,
	output gcode_pkg::char_t    last_char,
	output logic                success
);

	logic            is_digit;
	gcode_pkg::num_t digit;
	gcode_pkg::num_t next_num;

	assign is_digit = (char >= "0" && char <= "9");
	assign digit    = {3'b000, char[3:0]}; // ascii digits keep their value in the low nibble.
	assign next_num = cmd_num * 7'd10 + digit; // at most 99 after two digits.

	assign is_valid = gcode_pkg::is_supported_code(cmd_num);

	always_ff @(posedge clk) begin
		if (reset) begin
			cmd_num   <= '0;
			last_char <= '0;
			success   <= 1'b0;
		end
		else if (clk_en) begin
			if (zero) begin
				cmd_num   <= '0;
				last_char <= '0;
				success   <= 1'b0;
			end
			else begin
				if (store) begin
					last_char <= char;
				end
				// a non-digit leaves the number as it was.
				if (advance_num && is_digit) begin
					cmd_num <= next_num;
				end
				if (set_success) begin
					success <= 1'b1;
				end
			end
		end
	end

endmodule : code_num_buffer

//--- hdl/gcode_pkg.sv
package gcode_pkg;

	typedef logic [7:0] char_t; // one ascii character.

	typedef enum logic [2:0] {
		CHAR_G,       // 'G' or 'g'.
		CHAR_NUM,     // '0' to '9'.
		CHAR_SPACE,
		CHAR_NEWLINE,
		CHAR_OTHER
	} char_type_t;

	typedef logic [6:0] num_t; // command number, 0 to 99.

	// true for the G codes this controller executes.
	function automatic logic is_supported_code(input num_t num);
		logic ok;
		case (num)
			7'd0,
			7'd1,
			7'd2,
			7'd3,
			7'd4,
			7'd20,
			7'd21,
			7'd28,
			7'd90,
			7'd91: ok = 1'b1;
			default: ok = 1'b0;
		endcase
		return ok;
	endfunction

endpackage : gcode_pkg

//--- hdl/line_buffer.sv
`timescale 1ns/1ps

module line_buffer #(
	parameter int BUF_DEPTH = 16
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                clk_en,
	input  logic                wr_en,
	input  gcode_pkg::char_t    wr_char,
	input  logic                rd_pop,
	output gcode_pkg::char_t    rd_data,
	output logic                is_empty,
	output logic                full
);

	localparam int PTR_W = $clog2(BUF_DEPTH);
	localparam int CNT_W = PTR_W + 1;
	localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(BUF_DEPTH);

	gcode_pkg::char_t mem [BUF_DEPTH]; // character storage.

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count; // characters held.
	logic             do_wr;
	logic             do_rd;

	assign is_empty = (count == '0);
	assign full     = (count == FULL_CNT);

	assign do_wr = wr_en && !full; // writes while full are dropped.
	assign do_rd = rd_pop && !is_empty;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else if (clk_en) begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1; // wraps at the power-of-two depth.
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// character storage and registered read data.
	always_ff @(posedge clk) begin
		if (clk_en) begin
			if (do_wr) begin
				mem[wr_ptr] <= wr_char;
			end
			if (do_rd) begin
				rd_data <= mem[rd_ptr]; // valid the cycle after the pop.
			end
		end
	end

endmodule : line_buffer

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -Wno-fatal --top-module cmd_subparser_tb \
		-f flist.f -o cmd_subparser_sim \
	&& ./obj_dir/cmd_subparser_sim \
	|| exit 1

//--- test/cmd_subparser_chk.sv
`timescale 1ns/1ps

module cmd_subparser_chk (
	input logic clk,
	input logic reset,
	input logic clk_en,
	input logic rd_done,
	input logic rd_trigger,
	input logic rdy,
	input logic set_success,
	input logic zero
);

	// reader done is a single enabled cycle.
	assert property (@(posedge clk) disable iff (reset) (rd_done && clk_en) |=> !rd_done)
		else $error("rd_done stayed high for more than one cycle");

	assert property (@(posedge clk) disable iff (reset) !(set_success && zero))
		else $error("set_success and zero high together");

	// rdy is only high in IDLE.
	assert property (@(posedge clk) disable iff (reset) !(rd_trigger && rdy))
		else $error("rd_trigger high in IDLE");

endmodule : cmd_subparser_chk

bind cmd_subparser_fsm cmd_subparser_chk u_cmd_subparser_chk (
	.clk         (clk),
	.reset       (reset),
	.clk_en      (clk_en),
	.rd_done     (rd_done),
	.rd_trigger  (rd_trigger),
	.rdy         (rdy),
	.set_success (set_success),
	.zero        (zero)
);

//--- test/cmd_subparser_tb.sv
`timescale 1ns/1ps

module cmd_subparser_tb;

	localparam int WATCHDOG_CYCLES = 20000; // ample for about 100 parses and the stall tests.

	logic             clk;
	logic             reset;
	logic             clk_en;
	logic             wr_en;
	gcode_pkg::char_t wr_char;
	logic             trigger;
	logic             full;
	logic             rdy;
	logic             done;
	logic             success;
	gcode_pkg::num_t  cmd_num;
	gcode_pkg::char_t last_char;

	logic [31:0]      lcg_state;
	gcode_pkg::char_t model_q[$]; // characters written but not yet parsed.

	cmd_subparser #(
		.BUF_DEPTH (16)
	) u_cmd_subparser (
		.clk       (clk),
		.reset     (reset),
		.clk_en    (clk_en),
		.wr_en     (wr_en),
		.wr_char   (wr_char),
		.trigger   (trigger),
		.full      (full),
		.rdy       (rdy),
		.done      (done),
		.success   (success),
		.cmd_num   (cmd_num),
		.last_char (last_char)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		abort_run("watchdog expired before the tests finished");
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic logic in_code_table(input gcode_pkg::num_t n);
		return n inside {7'd0, 7'd1, 7'd2, 7'd3, 7'd4, 7'd20, 7'd21, 7'd28, 7'd90, 7'd91};
	endfunction

	function automatic logic is_digit_char(input gcode_pkg::char_t c);
		return (c >= "0" && c <= "9");
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] %0t %s: got %b, expected %b", $time, what, got, exp));
		end
	endtask

	task automatic check_num(input string what, input gcode_pkg::num_t got,
			input gcode_pkg::num_t exp);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] %0t %s: got %0d, expected %0d", $time, what, got, exp));
		end
	endtask

	task automatic check_char(input string what, input gcode_pkg::char_t got,
			input gcode_pkg::char_t exp);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] %0t %s: got 8'h%h, expected 8'h%h",
				$time, what, got, exp));
		end
	endtask

	task automatic tick();
		@(posedge clk);
		#2;
	endtask

	task automatic write_char(input gcode_pkg::char_t c);
		wr_en   = 1'b1;
		wr_char = c;
		tick();
		wr_en   = 1'b0;
	endtask

	task automatic write_str(input string s);
		for (int i = 0; i < s.len(); i++) begin
			write_char(s[i]);
		end
	endtask

	task automatic start_parse();
		trigger = 1'b1;
		tick();
		trigger = 1'b0;
		check_bit("rdy after trigger", rdy, 1'b0);
		check_bit("done after trigger", done, 1'b0);
	endtask

	task automatic wait_rdy();
		int n;
		n = 0;
		while (!rdy) begin
			tick();
			n++;
			if (n > 400) begin
				abort_run("rdy did not return high after a parse");
			end
		end
		check_bit("done in idle", done, 1'b1);
		tick(); // first idle cycle latches last_char.
	endtask

	task automatic run_parse();
		start_parse();
		wait_rdy();
	endtask

	task automatic check_result(input logic s, input gcode_pkg::num_t n,
			input gcode_pkg::char_t c);
		check_bit("success", success, s);
		check_num("cmd_num", cmd_num, n);
		check_char("last_char", last_char, c);
	endtask

	// expected result from the characters the parse will consume.
	task automatic parse_and_compare();
		gcode_pkg::char_t c;
		logic             exp_ok;
		gcode_pkg::num_t  exp_num;
		exp_ok  = 1'b0;
		exp_num = '0;
		c = model_q.pop_front();
		if (c == "G" || c == "g") begin
			c = model_q.pop_front();
			if (is_digit_char(c)) begin
				exp_num = 7'(c - "0");
				c = model_q.pop_front();
				if (is_digit_char(c)) begin
					exp_num = exp_num * 7'd10 + 7'(c - "0");
					exp_ok  = in_code_table(exp_num);
				end
			end
		end
		run_parse();
		check_result(exp_ok, exp_num, c);
	endtask

	task automatic test_directed_codes();
		write_str("G01");
		run_parse();
		check_result(1'b1, 7'd1, "1");
		write_str("g90");
		run_parse();
		check_result(1'b1, 7'd90, "0");
		write_str("M03");
		run_parse();
		check_result(1'b0, 7'd0, "M");
		run_parse(); // parse resumes at the digit after M.
		check_result(1'b0, 7'd0, "0");
		run_parse();
		check_result(1'b0, 7'd0, "3");
		write_str("G5 ");
		run_parse();
		check_result(1'b0, 7'd5, " ");
		write_str("G55");
		run_parse();
		check_result(1'b0, 7'd55, "5");
	endtask

	task automatic test_empty_and_stall();
		trigger = 1'b1;
		repeat (10) begin
			tick();
			check_bit("rdy on empty buffer", rdy, 1'b1);
			check_bit("done on empty buffer", done, 1'b1);
		end
		trigger = 1'b0;
		write_str("G2");
		start_parse();
		repeat (30) begin
			tick();
		end
		check_bit("rdy while starved", rdy, 1'b0);
		check_char("last_char while starved", last_char, "2");
		check_num("cmd_num while starved", cmd_num, 7'd2);
		write_str("8");
		wait_rdy();
		check_result(1'b1, 7'd28, "8");
	endtask

	task automatic test_clock_enable_hold();
		write_str("G21");
		start_parse();
		repeat (3) begin
			tick();
		end
		clk_en = 1'b0;
		repeat (20) begin
			tick();
			check_bit("rdy while clock disabled", rdy, 1'b0);
		end
		clk_en = 1'b1;
		wait_rdy();
		check_result(1'b1, 7'd21, "1");
	endtask

	task automatic test_full_buffer();
		string s;
		s = "G20G21G28G90G91M";
		write_str(s);
		check_bit("full after 16 writes", full, 1'b1);
		write_char("X"); // dropped while full.
		for (int i = 0; i < s.len(); i++) begin
			model_q.push_back(s[i]);
		end
		while (model_q.size() > 0) begin
			parse_and_compare();
		end
		check_bit("full after draining", full, 1'b0);
	endtask

	task automatic test_random_commands();
		gcode_pkg::char_t cmd [3];
		for (int i = 0; i < 40; i++) begin
			lcg_state = lcg_next(lcg_state);
			cmd[0] = lcg_state[12] ? "G" : "M";
			cmd[1] = "0" + (lcg_state[23:16] % 8'd10);
			cmd[2] = "0" + (lcg_state[31:24] % 8'd10);
			for (int k = 0; k < 3; k++) begin
				write_char(cmd[k]);
				model_q.push_back(cmd[k]);
			end
			while (model_q.size() > 0) begin
				parse_and_compare(); // an M code leaves its digits for later parses.
			end
		end
	endtask

	initial begin
		reset     = 1'b1;
		clk_en    = 1'b1;
		wr_en     = 1'b0;
		wr_char   = '0;
		trigger   = 1'b0;
		lcg_state = 32'hae29;
		repeat (16) begin
			tick();
		end
		reset = 1'b0;
		check_bit("rdy after reset", rdy, 1'b1);
		check_bit("done after reset", done, 1'b1);
		check_bit("success after reset", success, 1'b0);
		check_bit("full after reset", full, 1'b0);
		test_directed_codes();
		test_empty_and_stall();
		test_clock_enable_hold();
		test_full_buffer();
		test_random_commands();
		$display(">>> PASS");
		$finish;
	end

endmodule : cmd_subparser_tb
